// ==== i2c_mem.f ====
hdl/i2c_pkg.sv
hdl/i2c_master.sv
hdl/i2c_mem_slave.sv
hdl/i2c_mem_top.sv
tests/i2c_mem_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP       = i2c_mem_tb
FILELIST  = i2c_mem.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/i2c_mem_patterns.txt ====
# columns in hex: op (0 write 1 read) dev_addr mem_addr wr_data rd_data ack_err
# rd_data is only compared for reads that the slave acknowledges
0 48 00 a5 00 0
0 48 03 3c 00 0
0 48 07 c3 00 0
0 48 0f 5a 00 0
1 48 00 00 a5 0
1 48 03 00 3c 0
1 48 07 00 c3 0
1 48 0f 00 5a 0
0 48 04 11 00 0
0 48 03 e7 00 0
1 48 03 00 e7 0
1 48 04 00 11 0
0 49 03 ff 00 1
1 22 03 00 00 1
1 48 03 00 e7 0
0 48 13 77 00 1
1 48 a5 00 00 1
0 48 80 99 00 1
1 48 00 00 a5 0
1 48 0f 00 5a 0

// ==== tests/i2c_mem_tb.sv ====
`timescale 1ns/10ps

module i2c_mem_tb;
    import i2c_pkg::*;

    localparam int MAX_PAT        = 64;
    localparam int EXTRA_START_AT = 50;           // cycles into a transfer
    localparam int IDLE_GAP       = 4 * SCL_DIV;  // one bit period of quiet bus

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      read;
    dev_addr_t dev_addr;
    mem_addr_t mem_addr;
    byte_t     wr_data;
    byte_t     rd_data;
    logic      busy;
    logic      done;
    logic      ack_err;

    logic [7:0] pat_op  [MAX_PAT];
    logic [7:0] pat_dev [MAX_PAT];
    logic [7:0] pat_mem [MAX_PAT];
    logic [7:0] pat_wr  [MAX_PAT];
    logic [7:0] pat_rd  [MAX_PAT];
    logic [7:0] pat_err [MAX_PAT];
    int         n_pat       = 0;
    int         done_total  = 0;
    int         cycles      = 0;
    int         cycle_limit = 0;  // set once the patterns are known

    i2c_mem_top i2c_mem_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .read     (read),
        .dev_addr (dev_addr),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .busy     (busy),
        .done     (done),
        .ack_err  (ack_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: the transactions did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // every done pulse the DUT gives, wanted or not
    always @(negedge clk)
    begin
        if (done)
            done_total <= done_total + 1;
    end

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("ERR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_patterns();
        int               fd;
        int               n;
        logic             at_end;
        logic [8*128-1:0] header;
        logic [7:0]       f_op;
        logic [7:0]       f_dev;
        logic [7:0]       f_mem;
        logic [7:0]       f_wr;
        logic [7:0]       f_rd;
        logic [7:0]       f_err;
        fd = $fopen("tests/i2c_mem_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file tests/i2c_mem_patterns.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing pattern file");
        end
        n = $fgets(header, fd);  // column description lines
        n = $fgets(header, fd);
        at_end = 1'b0;
        while (!at_end)
        begin
            n = $fscanf(fd, "%h %h %h %h %h %h\n", f_op, f_dev, f_mem, f_wr, f_rd, f_err);
            if (n == 6 && n_pat < MAX_PAT)
            begin
                pat_op[n_pat]  = f_op;
                pat_dev[n_pat] = f_dev;
                pat_mem[n_pat] = f_mem;
                pat_wr[n_pat]  = f_wr;
                pat_rd[n_pat]  = f_rd;
                pat_err[n_pat] = f_err;
                n_pat++;
            end
            else
                at_end = 1'b1;
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_pattern(input int idx);
        int   waited;
        logic finished;
        waited   = 0;
        finished = 1'b0;
        @(negedge clk);
        read     = pat_op[idx][0];
        dev_addr = pat_dev[idx][6:0];
        mem_addr = pat_mem[idx];
        wr_data  = pat_wr[idx];
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value(8'(busy), 8'h01, $sformatf("pattern %0d busy after start", idx));
        while (!finished)
        begin
            @(negedge clk);
            waited++;
            if (done)
                finished = 1'b1;
            else
            begin
                check_value(8'(busy), 8'h01, $sformatf("pattern %0d busy in transfer", idx));
                if (waited == EXTRA_START_AT)
                begin
                    start   = 1'b1;      // master is busy, must ignore this
                    read    = ~read;
                    wr_data = ~wr_data;
                end
                else if (waited == EXTRA_START_AT + 1)
                    start = 1'b0;
            end
        end
        check_value(8'(busy), 8'h00, $sformatf("pattern %0d busy at done", idx));
        check_value(8'(ack_err), pat_err[idx], $sformatf("pattern %0d ack_err", idx));
        if (pat_op[idx][0] && pat_err[idx] == 8'h00)
            check_value(rd_data, pat_rd[idx], $sformatf("pattern %0d rd_data", idx));
        repeat (IDLE_GAP)
        begin
            @(negedge clk);
            check_value(8'(done), 8'h00, $sformatf("pattern %0d second done", idx));
        end
    endtask

    initial
    begin
        int idx;
        rst_n    = 1'b0;
        start    = 1'b0;
        read     = 1'b0;
        dev_addr = '0;
        mem_addr = '0;
        wr_data  = '0;
        load_patterns();
        cycle_limit = n_pat * 29 * 4 * SCL_DIV + 200;
        apply_reset();
        for (idx = 0; idx < n_pat; idx++)
            run_pattern(idx);
        if (n_pat == 0 || done_total != n_pat)
        begin
            $display("saw %0d done pulses for %0d transactions", done_total, n_pat);
            $display("TEST RESULT: FAIL");
            $fatal(1, "done count mismatch");
        end
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== hdl/i2c_mem_top.sv ====
`timescale 1ns/10ps

module i2c_mem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               read,
    input  i2c_pkg::dev_addr_t dev_addr,
    input  i2c_pkg::mem_addr_t mem_addr,
    input  i2c_pkg::byte_t     wr_data,
    output i2c_pkg::byte_t     rd_data,
    output logic               busy,
    output logic               done,
    output logic               ack_err
);

    logic scl;          // wired-and serial clock
    logic sda;          // wired-and serial data
    logic m_scl_oe;
    logic m_sda_oe;
    logic s_sda_oe;

    // pull-up wins unless some device pulls low
    assign scl = ~m_scl_oe;
    assign sda = ~(m_sda_oe | s_sda_oe);

    i2c_master master (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .read     (read),
        .dev_addr (dev_addr),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .sda_in   (sda),
        .scl_oe   (m_scl_oe),
        .sda_oe   (m_sda_oe),
        .busy     (busy),
        .done     (done),
        .ack_err  (ack_err),
        .rd_data  (rd_data)
    );

    i2c_mem_slave slave (
        .clk    (clk),
        .rst_n  (rst_n),
        .scl_in (scl),
        .sda_in (sda),
        .sda_oe (s_sda_oe)
    );

endmodule

// ==== hdl/i2c_mem_slave.sv ====
`timescale 1ns/10ps

module i2c_mem_slave (
    input  logic clk,
    input  logic rst_n,
    input  logic scl_in,
    input  logic sda_in,
    output logic sda_oe
);
    import i2c_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_DEV,
        S_ACK_DEV,
        S_MEM,
        S_ACK_MEM,
        S_WDATA,
        S_ACK_WDATA,
        S_RDATA,
        S_ACK_RDATA
    } state_t;

    state_t            state;
    logic [2:0]        scl_sync;   // two sync stages plus one of history
    logic [2:0]        sda_sync;
    logic              scl_rise;
    logic              scl_fall;
    logic              scl_hi;
    logic              start_det;
    logic              stop_det;
    logic [2:0]        bit_cnt;
    logic              last_bit;
    logic              rw_r;
    logic              drive_nxt;  // applied on the next scl fall
    byte_t             rx;
    byte_t             rx_byte;
    byte_t             tx;
    logic [MEM_AW-1:0] addr_r;
    byte_t             mem [MEM_DEPTH];

    assign scl_rise  = scl_sync[1] & ~scl_sync[2];
    assign scl_fall  = ~scl_sync[1] & scl_sync[2];
    assign scl_hi    = scl_sync[1] & scl_sync[2];
    assign start_det = scl_hi & sda_sync[2] & ~sda_sync[1];
    assign stop_det  = scl_hi & ~sda_sync[2] & sda_sync[1];
    assign rx_byte   = {rx[6:0], sda_sync[1]};  // byte including this bit
    assign last_bit  = (bit_cnt == 3'd7);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_sync  <= 3'b111;    // idle bus is high
            sda_sync  <= 3'b111;
            state     <= S_IDLE;
            bit_cnt   <= 3'd0;
            rw_r      <= 1'b0;
            drive_nxt <= 1'b0;
            sda_oe    <= 1'b0;
        end
        else
        begin
            scl_sync <= {scl_sync[1:0], scl_in};
            sda_sync <= {sda_sync[1:0], sda_in};
            if (stop_det)
            begin
                state     <= S_IDLE;
                drive_nxt <= 1'b0;
                sda_oe    <= 1'b0;
            end
            else if (start_det)
            begin
                state     <= S_DEV;
                bit_cnt   <= 3'd0;
                drive_nxt <= 1'b0;
            end
            else
            begin
                if (scl_fall)
                    sda_oe <= drive_nxt;
                if (scl_rise)
                begin
                    case (state)
                        S_DEV:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (last_bit)
                            begin
                                if (rx_byte[7:1] == SLAVE_ADDR)
                                begin
                                    state     <= S_ACK_DEV;
                                    drive_nxt <= 1'b1;
                                    rw_r      <= rx_byte[0];
                                end
                                else
                                    state <= S_IDLE;   // not ours, stay off the bus
                            end
                        end
                        S_ACK_DEV:
                        begin
                            state     <= S_MEM;
                            drive_nxt <= 1'b0;
                        end
                        S_MEM:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (last_bit)
                            begin
                                if (rx_byte < mem_addr_t'(MEM_DEPTH))
                                begin
                                    state     <= S_ACK_MEM;
                                    drive_nxt <= 1'b1;
                                end
                                else
                                    state <= S_IDLE;   // out of range, nack
                            end
                        end
                        S_ACK_MEM:
                            if (rw_r)
                            begin
                                state     <= S_RDATA;
                                drive_nxt <= ~mem[addr_r][7];  // first read bit
                            end
                            else
                            begin
                                state     <= S_WDATA;
                                drive_nxt <= 1'b0;
                            end
                        S_WDATA:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (last_bit)
                            begin
                                state     <= S_ACK_WDATA;
                                drive_nxt <= 1'b1;
                            end
                        end
                        S_RDATA:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (last_bit)
                            begin
                                state     <= S_ACK_RDATA;
                                drive_nxt <= 1'b0;     // master's ack slot
                            end
                            else
                                drive_nxt <= ~tx[7];
                        end
                        default:
                        begin
                            state     <= S_IDLE;       // single byte only
                            drive_nxt <= 1'b0;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (scl_rise)
        begin
            case (state)
                S_DEV, S_MEM, S_WDATA: rx <= rx_byte;
                S_ACK_MEM:             tx <= {mem[addr_r][6:0], 1'b0};
                S_RDATA:               tx <= {tx[6:0], 1'b0};
                default:               rx <= rx;
            endcase
            if (state == S_MEM && last_bit)
                addr_r <= rx_byte[MEM_AW-1:0];
            if (state == S_WDATA && last_bit)
                mem[addr_r] <= rx_byte;
        end
    end

endmodule

// ==== hdl/i2c_master.sv ====
`timescale 1ns/10ps

module i2c_master (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               read,
    input  i2c_pkg::dev_addr_t dev_addr,
    input  i2c_pkg::mem_addr_t mem_addr,
    input  i2c_pkg::byte_t     wr_data,
    input  logic               sda_in,
    output logic               scl_oe,
    output logic               sda_oe,
    output logic               busy,
    output logic               done,
    output logic               ack_err,
    output i2c_pkg::byte_t     rd_data
);
    import i2c_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_DEV,
        ST_RW,
        ST_ACK_DEV,
        ST_MEM,
        ST_ACK_MEM,
        ST_DATA,
        ST_ACK_DATA,
        ST_STOP,
        ST_FINISH
    } state_t;

    state_t           state;
    logic [DIV_W-1:0] q_cnt;     // clk cycles within a quarter
    logic [1:0]       phase;     // quarter within a bit period
    logic [2:0]       bit_cnt;
    byte_t            shift;
    mem_addr_t        mem_r;
    byte_t            wr_r;
    logic             rd_r;
    logic             sda_smp;   // bus level seen in the third quarter
    logic             drive_low;
    logic             tick;
    logic             bit_end;

    assign tick    = (q_cnt == DIV_W'(SCL_DIV - 1));
    assign bit_end = tick && (phase == 2'd3);

    // level the master puts on sda for the current bit
    always_comb
    begin
        case (state)
            ST_DEV, ST_MEM: drive_low = ~shift[7];
            ST_RW:          drive_low = ~rd_r;              // 1 = read, released
            ST_DATA:        drive_low = ~rd_r & ~shift[7];  // slave drives on read
            ST_STOP:        drive_low = 1'b1;
            default:        drive_low = 1'b0;               // ack slots released
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            q_cnt   <= '0;
            phase   <= 2'd0;
            bit_cnt <= 3'd0;
            rd_r    <= 1'b0;
            sda_smp <= 1'b1;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            ack_err <= 1'b0;
            rd_data <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (state == ST_IDLE)
            begin
                if (start)
                begin
                    state   <= ST_START;
                    busy    <= 1'b1;
                    rd_r    <= read;
                    ack_err <= 1'b0;
                    rd_data <= '0;
                    q_cnt   <= '0;
                    phase   <= 2'd0;
                end
            end
            else if (state == ST_FINISH)
            begin
                state <= ST_IDLE;
                busy  <= 1'b0;
                done  <= 1'b1;
            end
            else
            begin
                q_cnt <= tick ? '0 : q_cnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    case (phase)
                        2'd0: sda_oe <= drive_low;  // data changes while scl low
                        2'd1:
                        begin
                            scl_oe <= 1'b0;         // scl rises
                            if (state == ST_START)
                                sda_oe <= 1'b1;     // start: sda falls, scl high
                        end
                        2'd2:
                        begin
                            sda_smp <= sda_in;
                            if (state == ST_STOP)
                                sda_oe <= 1'b0;     // stop: sda rises, scl high
                        end
                        default:
                        begin
                            scl_oe <= 1'b1;         // scl falls into next bit
                            case (state)
                                ST_START:
                                begin
                                    state   <= ST_DEV;
                                    bit_cnt <= 3'd6;
                                end
                                ST_DEV:
                                    if (bit_cnt == 3'd0)
                                        state <= ST_RW;
                                    else
                                        bit_cnt <= bit_cnt - 3'd1;
                                ST_RW:
                                    state <= ST_ACK_DEV;
                                ST_ACK_DEV:
                                    if (sda_smp)
                                    begin
                                        ack_err <= 1'b1;
                                        state   <= ST_STOP;
                                    end
                                    else
                                    begin
                                        state   <= ST_MEM;
                                        bit_cnt <= 3'd7;
                                    end
                                ST_MEM:
                                    if (bit_cnt == 3'd0)
                                        state <= ST_ACK_MEM;
                                    else
                                        bit_cnt <= bit_cnt - 3'd1;
                                ST_ACK_MEM:
                                    if (sda_smp)
                                    begin
                                        ack_err <= 1'b1;
                                        state   <= ST_STOP;
                                    end
                                    else
                                    begin
                                        state   <= ST_DATA;
                                        bit_cnt <= 3'd7;
                                    end
                                ST_DATA:
                                    if (bit_cnt == 3'd0)
                                    begin
                                        state <= ST_ACK_DATA;
                                        if (rd_r)
                                            rd_data <= shift;
                                    end
                                    else
                                        bit_cnt <= bit_cnt - 3'd1;
                                ST_ACK_DATA:
                                begin
                                    if (!rd_r && sda_smp)
                                        ack_err <= 1'b1;    // write data nacked
                                    state <= ST_STOP;
                                end
                                default:
                                begin
                                    scl_oe <= 1'b0;         // bus left idle after stop
                                    state  <= ST_FINISH;
                                end
                            endcase
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start)
        begin
            shift <= {dev_addr, 1'b0};
            mem_r <= mem_addr;
            wr_r  <= wr_data;
        end
        else if (tick && phase == 2'd2 && state == ST_DATA && rd_r)
            shift <= {shift[6:0], sda_in};      // read data, msb first
        else if (bit_end)
        begin
            case (state)
                ST_DEV, ST_MEM: shift <= {shift[6:0], 1'b0};
                ST_DATA:
                    if (!rd_r)
                        shift <= {shift[6:0], 1'b0};
                ST_ACK_DEV:     shift <= mem_r;
                ST_ACK_MEM:     shift <= wr_r;
                default:        shift <= shift;
            endcase
        end
    end

endmodule

// ==== hdl/i2c_pkg.sv ====
package i2c_pkg;

    // data byte on the bus, also used by the shift registers
    typedef logic [7:0] byte_t;

    // 7-bit device address
    typedef logic [6:0] dev_addr_t;

    // register address inside the slave
    typedef logic [7:0] mem_addr_t;

    // address the memory slave answers to
    localparam dev_addr_t SLAVE_ADDR = 7'h48;

    // number of slave registers, addresses at or above are nacked
    localparam int MEM_DEPTH = 16;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);  // register index width

    // clk cycles per quarter of an scl period, so one bit is 4 * SCL_DIV
    localparam int SCL_DIV = 8;
    localparam int DIV_W   = $clog2(SCL_DIV);     // quarter counter width

endpackage
